// ==== Makefile ====
TOP = memAccessStageTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass line"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== dv/memAccessStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccessStageTb
	import mipsTypesPkg::*, memAccessPkg::*;
();

	localparam int period      = 100;
	localparam int resetCycles = 5;
	localparam int numCycles   = 2000;
	localparam logic [15:0] lfsrSeed = 16'd56789;

	// clock and reset
	logic    clk;
	logic    arstN;
	// dut inputs
	wordT    pcAddr;
	wordT    addr;
	logic    storeValid;
	memSizeT storeSize;
	wordT    storeData;
	logic    loadValid;
	memSizeT loadSize;
	logic    loadSigned;
	regIdxT  loadReg;
	wordT    readData;
	// dut outputs
	byteEnT  byteEn;
	wordT    writeDataOut;
	logic    loadDone;
	wordT    loadResult;
	regIdxT  loadRegW;
	logic    hasException;
	excCodeT excCode;
	wordT    badAddr;

	// model state
	logic [15:0] lfsrState;
	int          errors;
	int          checks;
	byteEnT      expByteEn;
	wordT        expData;
	logic        checkData;
	logic        expExc;
	excCodeT     expCode;
	wordT        expBad;
	// expected writeback of at most one entry
	wordT        expResQ[$];
	regIdxT      expRegQ[$];

	memAccessStage uut (
		.clk         (clk),
		.arstN       (arstN),
		.pcAddr      (pcAddr),
		.addr        (addr),
		.storeValid  (storeValid),
		.storeSize   (storeSize),
		.storeData   (storeData),
		.loadValid   (loadValid),
		.loadSize    (loadSize),
		.loadSigned  (loadSigned),
		.loadReg     (loadReg),
		.readData    (readData),
		.byteEn      (byteEn),
		.writeDataOut(writeDataOut),
		.loadDone    (loadDone),
		.loadResult  (loadResult),
		.loadRegW    (loadRegW),
		.hasException(hasException),
		.excCode     (excCode),
		.badAddr     (badAddr)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// ========================================
	// random source
	// ========================================

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one lfsr step per bit taken
	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	// ========================================
	// reference model
	// ========================================

	function automatic logic isMisaligned(input memSizeT size, input logic [1:0] low);
		if (size == sizeWord)
			return low != 2'b00;
		if (size == sizeHalf)
			return low[0];
		return 1'b0;
	endfunction

	function automatic byteEnT laneMask(input memSizeT size, input logic [1:0] low);
		if (size == sizeWord)
			return 4'b1111;
		if (size == sizeHalf)
			return low[1] ? 4'b1100 : 4'b0011;
		case (low)
			2'd0:    return 4'b0001;
			2'd1:    return 4'b0010;
			2'd2:    return 4'b0100;
			default: return 4'b1000;
		endcase
	endfunction

	function automatic wordT replicateData(input memSizeT size, input wordT d);
		if (size == sizeByte)
			return {d[7:0], d[7:0], d[7:0], d[7:0]};
		if (size == sizeHalf)
			return {d[15:0], d[15:0]};
		return d;
	endfunction

	function automatic wordT extractLoad(input memSizeT size, input logic sgn,
			input logic [1:0] low, input wordT rd);
		wordT v;
		if (size == sizeByte) begin
			v = (rd >> (8 * low)) & 32'h0000_00ff;
			if (sgn && v[7])
				v = v | 32'hffff_ff00;
		end else if (size == sizeHalf) begin
			v = (rd >> (16 * low[1])) & 32'h0000_ffff;
			if (sgn && v[15])
				v = v | 32'hffff_0000;
		end else begin
			v = rd;
		end
		return v;
	endfunction

	// ========================================
	// stimulus and checks
	// ========================================

	// new request plus its expected response
	task automatic driveCycle();
		logic [31:0] r;
		logic [1:0]  op;
		logic        pcBad;
		logic        stMis;
		logic        ldMis;
		randBits(2, r);
		op = r[1:0];
		randBits(32, r);
		addr = r;
		randBits(2, r);
		// unused code 3 folds onto word
		storeSize = (r[1:0] == 2'd3) ? sizeWord : memSizeT'(r[1:0]);
		loadSize  = storeSize;
		randBits(1, r);
		loadSigned = r[0];
		randBits(5, r);
		loadReg = r[4:0];
		randBits(32, r);
		storeData = r;
		randBits(32, r);
		readData = r;
		// bad pc about one cycle in sixteen
		randBits(4, r);
		pcBad = (r[3:0] == 4'd0);
		randBits(32, r);
		pcAddr = pcBad ? {r[31:2], ((r[1:0] == 2'b00) ? 2'b01 : r[1:0])} : {r[31:2], 2'b00};
		// never both at once
		storeValid = (op == 2'd2);
		loadValid  = (op == 2'd1);

		stMis     = storeValid && isMisaligned(storeSize, addr[1:0]);
		ldMis     = loadValid && isMisaligned(loadSize, addr[1:0]);
		checkData = storeValid && !stMis;
		expByteEn = checkData ? laneMask(storeSize, addr[1:0]) : 4'b0000;
		expData   = replicateData(storeSize, storeData);
		// fetch first, then load, then store
		if (pcAddr[1:0] != 2'b00) begin
			expExc  = 1'b1;
			expCode = excAdEL;
			expBad  = pcAddr;
		end else if (ldMis) begin
			expExc  = 1'b1;
			expCode = excAdEL;
			expBad  = addr;
		end else if (stMis) begin
			expExc  = 1'b1;
			expCode = excAdES;
			expBad  = addr;
		end else begin
			expExc  = 1'b0;
			expCode = '0;
			expBad  = '0;
		end
		if (loadValid && !ldMis) begin
			expResQ.push_back(extractLoad(loadSize, loadSigned, addr[1:0], readData));
			expRegQ.push_back(loadReg);
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
		errors++;
	endtask

	// sampled just before the falling edge
	task automatic checkCycle();
		logic   expDone;
		wordT   expRes;
		regIdxT expReg;
		checks++;
		if (byteEn !== expByteEn)
			reportMismatch("store byteEn", 32'(expByteEn), 32'(byteEn));
		if (checkData && writeDataOut !== expData)
			reportMismatch("store data", expData, writeDataOut);
		if (hasException !== expExc)
			reportMismatch("exception flag", 32'(expExc), 32'(hasException));
		if (excCode !== expCode)
			reportMismatch("exception code", 32'(expCode), 32'(excCode));
		if (badAddr !== expBad)
			reportMismatch("bad address", expBad, badAddr);
		// writeback of the load sampled on the last rising edge
		expDone = (expResQ.size() != 0);
		if (loadDone !== expDone)
			reportMismatch("load done", 32'(expDone), 32'(loadDone));
		if (expDone) begin
			expRes = expResQ.pop_front();
			expReg = expRegQ.pop_front();
			if (loadResult !== expRes)
				reportMismatch("load result", expRes, loadResult);
			if (loadRegW !== expReg)
				reportMismatch("load register", 32'(expReg), 32'(loadRegW));
		end else if (loadResult !== '0) begin
			reportMismatch("idle load result", 32'h0, loadResult);
		end
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		lfsrState  = lfsrSeed;
		errors     = 0;
		checks     = 0;
		arstN      = 1'b0;
		pcAddr     = '0;
		addr       = '0;
		storeValid = 1'b0;
		storeSize  = sizeByte;
		storeData  = '0;
		loadValid  = 1'b0;
		loadSize   = sizeByte;
		loadSigned = 1'b0;
		loadReg    = '0;
		readData   = '0;
		// five rising edges in reset, release on a falling edge
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		// idle state right after reset
		@(posedge clk);
		#40;
		if (loadDone !== 1'b0)
			reportMismatch("reset load done", 32'h0, 32'(loadDone));
		if (loadResult !== '0)
			reportMismatch("reset load result", 32'h0, loadResult);
		if (loadRegW !== '0)
			reportMismatch("reset load register", 32'h0, 32'(loadRegW));
		if (byteEn !== '0)
			reportMismatch("reset byteEn", 32'h0, 32'(byteEn));
		if (hasException !== 1'b0)
			reportMismatch("reset exception flag", 32'h0, 32'(hasException));

		for (int i = 0; i < numCycles; i++) begin
			@(negedge clk);
			driveCycle();
			@(posedge clk);
			#40;
			checkCycle();
		end

		$display("checked %0d cycles, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog at twice the expected run length
	initial begin
		#(2 * (numCycles + resetCycles + 2) * period);
		$display("timeout: the test did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/memAccessStage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccessStageSva
	import mipsTypesPkg::*, memAccessPkg::*;
(
	input logic    clk,
	input logic    arstN,
	input logic    storeValid,
	input logic    loadValid,
	input byteEnT  byteEn,
	input logic    loadDone,
	input logic    hasException,
	input excCodeT excCode
);

	// ========================================
	// request and response rules
	// ========================================

	// one access per cycle
	noDualAccess: assert property (@(posedge clk) disable iff (!arstN)
		!(storeValid && loadValid))
		else $error("store and load requested in the same cycle");

	// memory is never written without a store
	quietByteEn: assert property (@(posedge clk) disable iff (!arstN)
		!storeValid |-> (byteEn == 4'b0000))
		else $error("byte enables active with no store");

	// writeback follows a load by one cycle
	doneAfterLoad: assert property (@(posedge clk) disable iff (!arstN)
		loadDone |-> $past(loadValid))
		else $error("load done without a load in the previous cycle");

	// only address error codes exist here
	legalCode: assert property (@(posedge clk) disable iff (!arstN)
		hasException |-> (excCode == excAdEL || excCode == excAdES))
		else $error("exception raised with an unknown code");

endmodule

bind memAccessStage memAccessStageSva sva (
	.clk         (clk),
	.arstN       (arstN),
	.storeValid  (storeValid),
	.loadValid   (loadValid),
	.byteEn      (byteEn),
	.loadDone    (loadDone),
	.hasException(hasException),
	.excCode     (excCode)
);

`default_nettype wire

// ==== hdl/accessException.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessException
	import mipsTypesPkg::*, memAccessPkg::*;
(
	input  wordT    pcAddr,
	input  wordT    addr,
	input  logic    loadMisaligned,
	input  logic    storeMisaligned,
	output logic    hasException,
	output excCodeT excCode,
	output wordT    badAddr
);

	// instruction fetch from a non-word address
	logic fetchError;

	assign fetchError = (pcAddr[1:0] != 2'b00);

	// ========================================
	// prioritised selection
	// ========================================

	// fetch is the oldest fault, so it wins
	// then load, then store
	always_comb begin
		if (fetchError) begin
			hasException = 1'b1;
			excCode      = excAdEL;
			// faulting pc goes to BadVAddr
			badAddr      = pcAddr;
		end else if (loadMisaligned) begin
			hasException = 1'b1;
			excCode      = excAdEL;
			badAddr      = addr;
		end else if (storeMisaligned) begin
			hasException = 1'b1;
			excCode      = excAdES;
			badAddr      = addr;
		end else begin
			// nothing to report
			hasException = 1'b0;
			excCode      = '0;
			badAddr      = '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/loadAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadAlign
	import mipsTypesPkg::*, memAccessPkg::*;
(
	input  logic       clk,
	input  logic       arstN,
	// memory stage
	input  logic       loadValid,
	input  memSizeT    loadSize,
	input  logic       loadSigned,
	input  logic [1:0] addrLow,
	input  regIdxT     loadReg,
	input  wordT       readData,
	output logic       loadMisaligned,
	// writeback stage
	output logic       loadDone,
	output wordT       loadResult,
	output regIdxT     loadRegW
);

	// memory stage
	logic misalign;

	// writeback stage registers
	logic       validW;
	regIdxT     regW;
	memSizeT    sizeW;
	logic       signW;
	logic [1:0] addrLowW;
	wordT       dataW;

	// extraction
	logic [7:0]  byteSel;
	logic [15:0] halfSel;
	wordT        extracted;

	// ========================================
	// memory stage, alignment check
	// ========================================

	always_comb begin
		case (loadSize)
			sizeWord: misalign = (addrLow != 2'b00);
			sizeHalf: misalign = addrLow[0];
			default:  misalign = 1'b0;
		endcase
	end

	// AdEL only for a real load
	assign loadMisaligned = loadValid & misalign;

	// ========================================
	// memory to writeback register
	// ========================================

	// control part, cleared by reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validW <= 1'b0;
			regW   <= '0;
		end else begin
			// a misaligned load never reaches writeback
			validW <= loadValid & ~misalign;
			if (loadValid)
				regW <= loadReg;
		end
	end

	// payload, captured with each load
	always_ff @(posedge clk) begin
		if (loadValid) begin
			sizeW    <= loadSize;
			signW    <= loadSigned;
			addrLowW <= addrLow;
			dataW    <= readData;
		end
	end

	// ========================================
	// writeback, lane pick and extension
	// ========================================

	// addressed byte lane
	assign byteSel = dataW[8*addrLowW +: 8];
	// halfword by address bit 1
	assign halfSel = addrLowW[1] ? dataW[31:16] : dataW[15:0];

	always_comb begin
		case (sizeW)
			// lb or lbu
			sizeByte: extracted = {{24{signW & byteSel[7]}}, byteSel};
			// lh or lhu
			sizeHalf: extracted = {{16{signW & halfSel[15]}}, halfSel};
			// lw, whole word
			default:  extracted = dataW;
		endcase
	end

	assign loadDone   = validW;
	// result is quiet between loads
	assign loadResult = validW ? extracted : '0;
	assign loadRegW   = regW;

endmodule

`default_nettype wire

// ==== hdl/memAccessPkg.sv ====
`default_nettype none

// ========================================
// memory stage encodings
// ========================================

package memAccessPkg;

	// access size of a load or store
	// code 3 is unused
	typedef logic [1:0] memSizeT;

	// lb, lbu, sb
	localparam memSizeT sizeByte = 2'd0;
	// lh, lhu, sh
	localparam memSizeT sizeHalf = 2'd1;
	// lw, sw
	localparam memSizeT sizeWord = 2'd2;

	// cause register exception code field
	typedef logic [4:0] excCodeT;

	// address error on fetch or load
	localparam excCodeT excAdEL = 5'd4;
	// address error on store
	localparam excCodeT excAdES = 5'd5;

endpackage

`default_nettype wire

// ==== hdl/memAccessStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccessStage
	import mipsTypesPkg::*, memAccessPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	// request
	input  wordT    pcAddr,
	input  wordT    addr,
	// store side
	input  logic    storeValid,
	input  memSizeT storeSize,
	input  wordT    storeData,
	// load side
	input  logic    loadValid,
	input  memSizeT loadSize,
	input  logic    loadSigned,
	input  regIdxT  loadReg,
	// memory word, same cycle as the load
	input  wordT    readData,
	// to memory
	output byteEnT  byteEn,
	output wordT    writeDataOut,
	// writeback
	output logic    loadDone,
	output wordT    loadResult,
	output regIdxT  loadRegW,
	// exception report
	output logic    hasException,
	output excCodeT excCode,
	output wordT    badAddr
);

	// byte offset within the word
	logic [1:0] addrLow;
	// alignment faults into the exception picker
	logic       storeMisaligned;
	logic       loadMisaligned;

	assign addrLow = addr[1:0];

	// ========================================
	// store path
	// ========================================

	storeAlign storeAlignInst (
		.storeValid     (storeValid),
		.storeSize      (storeSize),
		.addrLow        (addrLow),
		.storeData      (storeData),
		.byteEn         (byteEn),
		.writeDataOut   (writeDataOut),
		.storeMisaligned(storeMisaligned)
	);

	// ========================================
	// load path, one cycle to writeback
	// ========================================

	loadAlign loadAlignInst (
		.clk           (clk),
		.arstN         (arstN),
		.loadValid     (loadValid),
		.loadSize      (loadSize),
		.loadSigned    (loadSigned),
		.addrLow       (addrLow),
		.loadReg       (loadReg),
		.readData      (readData),
		.loadMisaligned(loadMisaligned),
		.loadDone      (loadDone),
		.loadResult    (loadResult),
		.loadRegW      (loadRegW)
	);

	// fetch, load and store faults merged
	accessException accessExceptionInst (
		.pcAddr         (pcAddr),
		.addr           (addr),
		.loadMisaligned (loadMisaligned),
		.storeMisaligned(storeMisaligned),
		.hasException   (hasException),
		.excCode        (excCode),
		.badAddr        (badAddr)
	);

endmodule

`default_nettype wire

// ==== hdl/mipsTypesPkg.sv ====
`default_nettype none

// ========================================
// architectural data types
// ========================================

package mipsTypesPkg;

	// one data word
	// also used for byte addresses
	typedef logic [31:0] wordT;

	// general purpose register number
	// 32 registers, r0 reads as zero
	typedef logic [4:0] regIdxT;

	// byte enables toward data memory
	// bit 0 is lane 0, the low byte of the word
	// little endian lane order
	typedef logic [3:0] byteEnT;

endpackage

`default_nettype wire

// ==== hdl/storeAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeAlign
	import mipsTypesPkg::*, memAccessPkg::*;
(
	input  logic    storeValid,
	input  memSizeT storeSize,
	// low two bits of the data address
	input  logic [1:0] addrLow,
	input  wordT    storeData,
	output byteEnT  byteEn,
	output wordT    writeDataOut,
	output logic    storeMisaligned
);

	// size-dependent misalignment, before qualification
	logic misalign;
	// lane enables assuming the store goes ahead
	byteEnT laneEn;

	// ========================================
	// alignment check
	// ========================================

	always_comb begin
		case (storeSize)
			// sw needs a word boundary
			sizeWord: misalign = (addrLow != 2'b00);
			// sh needs an even address
			sizeHalf: misalign = addrLow[0];
			// sb is always aligned
			default:  misalign = 1'b0;
		endcase
	end

	// only a real store raises AdES
	assign storeMisaligned = storeValid & misalign;

	// ========================================
	// lane select and replication
	// ========================================

	always_comb begin
		case (storeSize)
			sizeByte: begin
				// one lane, picked by both address bits
				laneEn       = byteEnT'(1) << addrLow;
				writeDataOut = {4{storeData[7:0]}};
			end
			sizeHalf: begin
				// upper or lower half by bit 1
				laneEn       = addrLow[1] ? 4'b1100 : 4'b0011;
				writeDataOut = {2{storeData[15:0]}};
			end
			sizeWord: begin
				laneEn       = 4'b1111;
				writeDataOut = storeData;
			end
			default: begin
				// unused size code, write nothing
				laneEn       = 4'b0000;
				writeDataOut = storeData;
			end
		endcase
	end

	// misaligned store is cancelled
	// memory sees no enables at all
	assign byteEn = (storeValid & ~misalign) ? laneEn : 4'b0000;

endmodule

`default_nettype wire

// ==== list.f ====
hdl/mipsTypesPkg.sv
hdl/memAccessPkg.sv
hdl/storeAlign.sv
hdl/loadAlign.sv
hdl/accessException.sv
hdl/memAccessStage.sv
dv/memAccessStage_sva.sv
dv/memAccessStageTb.sv
